// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_soc and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_soc -f project.f -o Vtb_soc
	./obj_dir/Vtb_soc +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/block_ram.sv ====
`timescale 1ns/1ns

module block_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic              i_clock,
	input  logic              i_request,
	input  soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus
);
	import soc_pkg::*;

	localparam int INDEX_WIDTH = $clog2(RAM_WORDS);

	logic [DATA_WIDTH-1:0]  mem [RAM_WORDS];
	logic [INDEX_WIDTH-1:0] index;
	logic [DATA_WIDTH-1:0]  rdata;
	logic                   ready = 1'b0;
	logic                   accept;

	// Word index wraps modulo RAM_WORDS
	assign index = i_bus.address[INDEX_WIDTH+1:2];

	// Only the first cycle of a held request is served
	assign accept = i_request && !ready;

	always_ff @(posedge i_clock) begin
		ready <= accept;
		if (accept) begin
			if (i_bus.rw) begin
				mem[index] <= i_bus.wdata;
			end
			rdata <= mem[index];
		end
	end

	assign o_bus = '{ready: ready, rdata: rdata};

endmodule

// ==== hw/bus_access.sv ====
`timescale 1ns/1ns

module bus_access (
	input  logic                           i_clock,
	input  logic                           i_reset,

	// Read-only instruction port
	input  logic                           i_ibus_request,
	input  logic [soc_pkg::ADDR_WIDTH-1:0] i_ibus_address,
	output soc_pkg::bus_rsp_t              o_ibus,

	// Data port
	input  logic                           i_dbus_request,
	input  soc_pkg::bus_req_t              i_dbus,
	output soc_pkg::bus_rsp_t              o_dbus,

	// Shared bus
	output logic                           o_bus_request,
	output soc_pkg::bus_req_t              o_bus,
	input  soc_pkg::bus_rsp_t              i_bus
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUS,
		S_RESP
	} state_t;

	state_t                state;
	// Set when the data port won the last grant
	logic                  last_dbus;
	logic                  grant_ibus;
	logic                  grant_dbus;
	logic [DATA_WIDTH-1:0] rdata;

	// ========================================================================
	// Round-robin grant
	// ========================================================================
	always_comb begin
		grant_ibus = 1'b0;
		grant_dbus = 1'b0;
		if (state == S_IDLE) begin
			if (i_ibus_request && i_dbus_request) begin
				// Tie goes to the port that lost last time
				grant_ibus = last_dbus;
				grant_dbus = !last_dbus;
			end else begin
				grant_ibus = i_ibus_request;
				grant_dbus = i_dbus_request;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= S_IDLE;
			o_bus_request <= 1'b0;
			last_dbus     <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (grant_ibus || grant_dbus) begin
						state         <= S_BUS;
						o_bus_request <= 1'b1;
						last_dbus     <= grant_dbus;
					end
				end
				S_BUS: begin
					if (i_bus.ready) begin
						state         <= S_RESP;
						o_bus_request <= 1'b0;
					end
				end
				S_RESP: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Payload and captured read data
	always_ff @(posedge i_clock) begin
		if (grant_dbus) begin
			o_bus <= i_dbus;
		end else if (grant_ibus) begin
			o_bus <= '{rw: 1'b0, address: i_ibus_address, wdata: '0};
		end
		if (state == S_BUS && i_bus.ready) begin
			rdata <= i_bus.rdata;
		end
	end

	// One-cycle ready back to the owner
	assign o_ibus = '{ready: (state == S_RESP) && !last_dbus, rdata: rdata};
	assign o_dbus = '{ready: (state == S_RESP) && last_dbus, rdata: rdata};

endmodule

// ==== hw/bus_bridge.sv ====
`timescale 1ns/1ns

module bus_bridge (
	input  logic              i_clock,
	input  logic              i_reset,

	// Near side
	input  logic              i_request,
	input  soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,

	// Far side
	output logic              o_far_request,
	output soc_pkg::bus_req_t o_far,
	input  soc_pkg::bus_rsp_t i_far
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FAR,
		S_RESP
	} state_t;

	state_t                state;
	logic [DATA_WIDTH-1:0] rdata;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= S_IDLE;
			o_far_request <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_request) begin
						state         <= S_FAR;
						o_far_request <= 1'b1;
					end
				end
				S_FAR: begin
					// Hold far request until the far side answers
					if (i_far.ready) begin
						state         <= S_RESP;
						o_far_request <= 1'b0;
					end
				end
				S_RESP: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Latched request and far response
	always_ff @(posedge i_clock) begin
		if (state == S_IDLE && i_request) begin
			o_far <= i_bus;
		end
		if (state == S_FAR && i_far.ready) begin
			rdata <= i_far.rdata;
		end
	end

	assign o_bus = '{ready: state == S_RESP, rdata: rdata};

endmodule

// ==== hw/far_peripherals.sv ====
`timescale 1ns/1ns

module far_peripherals (
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_request,
	input  soc_pkg::bus_req_t             i_bus,
	output soc_pkg::bus_rsp_t             o_bus,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds
);
	import soc_pkg::*;

	logic [3:0]            code;
	logic                  accept;
	logic                  ready;
	logic [DATA_WIDTH-1:0] rdata;
	logic [DATA_WIDTH-1:0] scratch;

	assign code   = i_bus.address[27:24];
	assign accept = i_request && !ready;

	// Handshake and LED register
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ready  <= 1'b0;
			o_leds <= '0;
		end else begin
			ready <= accept;
			if (accept && i_bus.rw && code == FAR_LED) begin
				o_leds <= i_bus.wdata[LED_WIDTH-1:0];
			end
		end
	end

	// Scratch word and read mux
	always_ff @(posedge i_clock) begin
		if (accept && i_bus.rw && code == FAR_SCRATCH) begin
			scratch <= i_bus.wdata;
		end
		if (accept) begin
			case (code)
				FAR_LED:     rdata <= DATA_WIDTH'(o_leds);
				FAR_SCRATCH: rdata <= scratch;
				FAR_ID:      rdata <= SOC_ID;
				// Unknown codes read zero
				default:     rdata <= '0;
			endcase
		end
	end

	assign o_bus = '{ready: ready, rdata: rdata};

endmodule

// ==== hw/soc_pkg.sv ====
package soc_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// One 65-bit request on any link
	typedef struct packed {
		logic                  rw;
		logic [ADDR_WIDTH-1:0] address;
		logic [DATA_WIDTH-1:0] wdata;
	} bus_req_t;

	// One 33-bit response on any link
	typedef struct packed {
		logic                  ready;
		logic [DATA_WIDTH-1:0] rdata;
	} bus_rsp_t;

	// ========================================================================
	// Address map
	// ========================================================================

	// Near regions compared with address bits 31:28
	localparam logic [3:0] REGION_RAM    = 4'h1;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	// Far registers behind the bridge use address bits 27:24
	localparam logic [3:0] FAR_LED     = 4'h0;
	localparam logic [3:0] FAR_SCRATCH = 4'h1;
	localparam logic [3:0] FAR_ID      = 4'h2;

	// ========================================================================
	// Peripheral constants
	// ========================================================================
	localparam int LED_WIDTH = 10;

	// Returned by the identification register
	localparam logic [DATA_WIDTH-1:0] SOC_ID = 32'h50C0_0001;

endpackage

// ==== hw/soc_top.sv ====
`timescale 1ns/1ns

module soc_top #(
	parameter int RAM_WORDS = 256
) (
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_ibus_request,
	input  logic [soc_pkg::ADDR_WIDTH-1:0] i_ibus_address,
	input  logic                           i_dbus_request,
	input  soc_pkg::bus_req_t              i_dbus,
	output soc_pkg::bus_rsp_t              o_ibus,
	output soc_pkg::bus_rsp_t              o_dbus,
	output logic [soc_pkg::LED_WIDTH-1:0]  o_leds,
	output logic                           o_bus_fault,
	output logic [soc_pkg::ADDR_WIDTH-1:0] o_fault_address
);
	import soc_pkg::*;

	logic       bus_request;
	bus_req_t   bus;
	bus_rsp_t   bus_rsp;
	bus_rsp_t   ram_rsp;
	bus_rsp_t   bridge_rsp;
	logic       far_request;
	bus_req_t   far_req;
	bus_rsp_t   far_rsp;
	logic [3:0] region;
	logic       ram_select;
	logic       bridge_select;
	logic       fault_ready;

	bus_access u_bus_access (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus         (o_ibus),
		.i_dbus_request (i_dbus_request),
		.i_dbus         (i_dbus),
		.o_dbus         (o_dbus),
		.o_bus_request  (bus_request),
		.o_bus          (bus),
		.i_bus          (bus_rsp)
	);

	// ========================================================================
	// Near decode
	// ========================================================================
	assign region        = bus.address[31:28];
	assign ram_select    = region == REGION_RAM;
	assign bridge_select = region == REGION_BRIDGE;

	block_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_block_ram (
		.i_clock   (i_clock),
		.i_request (ram_select && bus_request),
		.i_bus     (bus),
		.o_bus     (ram_rsp)
	);

	bus_bridge u_bus_bridge (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (bridge_select && bus_request),
		.i_bus         (bus),
		.o_bus         (bridge_rsp),
		.o_far_request (far_request),
		.o_far         (far_req),
		.i_far         (far_rsp)
	);

	far_peripherals u_far_peripherals (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (far_request),
		.i_bus     (far_req),
		.o_bus     (far_rsp),
		.o_leds    (o_leds)
	);

	always_comb begin
		if (ram_select) begin
			bus_rsp = ram_rsp;
		end else if (bridge_select) begin
			bus_rsp = bridge_rsp;
		end else begin
			// Unmapped regions still answer so the bus never hangs
			bus_rsp = '{ready: fault_ready, rdata: '0};
		end
	end

	// ========================================================================
	// Bus fault capture
	// ========================================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			fault_ready     <= 1'b0;
			o_bus_fault     <= 1'b0;
			o_fault_address <= '0;
		end else begin
			fault_ready <= bus_request && !ram_select && !bridge_select && !fault_ready;
			if (bus_request && !ram_select && !bridge_select && !o_bus_fault) begin
				// First fault only
				o_bus_fault     <= 1'b1;
				o_fault_address <= bus.address;
			end
		end
	end

endmodule

// ==== project.f ====
hw/soc_pkg.sv
hw/bus_access.sv
hw/block_ram.sv
hw/bus_bridge.sv
hw/far_peripherals.sv
hw/soc_top.sv
sim/soc_props.sv
sim/tb_soc.sv

// ==== sim/soc_props.sv ====
`timescale 1ns/1ns

module soc_props (
	input logic              i_clock,
	input logic              i_reset,
	input logic              i_ibus_request,
	input logic              i_dbus_request,
	input soc_pkg::bus_rsp_t o_ibus,
	input soc_pkg::bus_rsp_t o_dbus,
	input logic              o_bus_request,
	input soc_pkg::bus_req_t o_bus,
	input soc_pkg::bus_rsp_t i_bus
);
	// Count of failed assertions
	int failures = 0;

	// A port ready is a single-cycle pulse
	ready_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_ibus.ready || o_dbus.ready) |=> !(o_ibus.ready || o_dbus.ready))
	else begin
		failures++;
		$error("port ready stayed high for more than one cycle");
	end

	// Ready only goes to a port that is still requesting
	ready_has_request: assert property (@(posedge i_clock) disable iff (i_reset)
		(!o_ibus.ready || i_ibus_request) && (!o_dbus.ready || i_dbus_request))
	else begin
		failures++;
		$error("port ready without a pending port request");
	end

	// Shared bus holds request and payload until the target answers
	bus_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus.ready) |=> (o_bus_request && $stable(o_bus)))
	else begin
		failures++;
		$error("shared bus request dropped or changed before bus ready");
	end

endmodule

bind bus_access soc_props u_soc_props (
	.i_clock(i_clock), .i_reset(i_reset),
	.i_ibus_request(i_ibus_request), .i_dbus_request(i_dbus_request),
	.o_ibus(o_ibus), .o_dbus(o_dbus),
	.o_bus_request(o_bus_request), .o_bus(o_bus), .i_bus(i_bus)
);

// ==== sim/tb_soc.sv ====
`timescale 1ns/1ns

module tb_soc;
	import soc_pkg::*;

	// About ten times the longest test section
	localparam int MAX_CYCLES = 4000;
	localparam int RAM_WORDS  = 256;
	localparam int RAM_TESTS  = 16;
	// Uncontended port request to port ready
	localparam int LATENCY    = 4;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  ibus_request;
	logic [ADDR_WIDTH-1:0] ibus_address;
	logic                  dbus_request;
	bus_req_t              dbus;
	bus_rsp_t              ibus_rsp;
	bus_rsp_t              dbus_rsp;
	logic [LED_WIDTH-1:0]  leds;
	logic                  bus_fault;
	logic [ADDR_WIDTH-1:0] fault_address;

	integer                seed = 32'h1523_9193;
	int                    cycles = 0;
	int                    value_errors = 0;
	int                    ibus_issued = 0;
	int                    dbus_issued = 0;
	int                    ibus_readies = 0;
	int                    dbus_readies = 0;
	logic [ADDR_WIDTH-1:0] ram_addresses [RAM_TESTS];

	// Reference model
	logic [DATA_WIDTH-1:0] ram_model [RAM_WORDS];
	logic [LED_WIDTH-1:0]  led_model;
	logic [DATA_WIDTH-1:0] scratch_model;
	logic                  fault_flag_model;
	logic [ADDR_WIDTH-1:0] fault_address_model;

	soc_top #(.RAM_WORDS(RAM_WORDS)) u_soc_top (
		.i_clock(clock), .i_reset(reset),
		.i_ibus_request(ibus_request), .i_ibus_address(ibus_address),
		.i_dbus_request(dbus_request), .i_dbus(dbus),
		.o_ibus(ibus_rsp), .o_dbus(dbus_rsp), .o_leds(leds),
		.o_bus_fault(bus_fault), .o_fault_address(fault_address)
	);

	always #20 clock = ~clock;

	// Run limit and one count per port ready
	always @(posedge clock) begin
		cycles       <= cycles + 1;
		ibus_readies <= ibus_readies + int'(ibus_rsp.ready);
		dbus_readies <= dbus_readies + int'(dbus_rsp.ready);
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: a port did not answer within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("Fail %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
	endtask

	task automatic dbus_access(input logic rw, input logic [ADDR_WIDTH-1:0] address,
		input logic [DATA_WIDTH-1:0] wdata, output logic [DATA_WIDTH-1:0] rdata,
		output int latency);
		latency = 0;
		@(posedge clock);
		dbus_request <= 1'b1;
		dbus         <= '{rw: rw, address: address, wdata: wdata};
		dbus_issued++;
		do begin
			@(posedge clock);
			latency++;
		end while (!dbus_rsp.ready);
		rdata = dbus_rsp.rdata;
		dbus_request <= 1'b0;
	endtask

	task automatic ibus_read(input logic [ADDR_WIDTH-1:0] address,
		output logic [DATA_WIDTH-1:0] rdata, output int latency);
		latency = 0;
		@(posedge clock);
		ibus_request <= 1'b1;
		ibus_address <= address;
		ibus_issued++;
		do begin
			@(posedge clock);
			latency++;
		end while (!ibus_rsp.ready);
		rdata = ibus_rsp.rdata;
		ibus_request <= 1'b0;
	endtask

	// RAM word selected by an address wraps at RAM_WORDS
	function automatic int ram_index(input logic [ADDR_WIDTH-1:0] address);
		return int'((address >> 2) % RAM_WORDS);
	endfunction

	initial begin
		logic [DATA_WIDTH-1:0] data;
		logic [DATA_WIDTH-1:0] rdata;
		logic [DATA_WIDTH-1:0] rnd;
		int                    latency;
		int                    ibus_latency;

		ibus_request <= 1'b0;
		ibus_address <= '0;
		dbus_request <= 1'b0;
		dbus         <= '0;
		apply_reset();
		check_value("o_ibus.ready", 0, DATA_WIDTH'(ibus_rsp.ready));
		check_value("o_dbus.ready", 0, DATA_WIDTH'(dbus_rsp.ready));
		check_value("o_leds", 0, DATA_WIDTH'(leds));
		check_value("o_bus_fault", 0, DATA_WIDTH'(bus_fault));

		// ====================================================================
		// RAM through the data port
		// ====================================================================
		for (int i = 0; i < RAM_TESTS; i++) begin
			rnd  = $random(seed);
			data = $random(seed);
			ram_addresses[i] = {REGION_RAM, rnd[27:2], 2'b00};
			dbus_access(1'b1, ram_addresses[i], data, rdata, latency);
			ram_model[ram_index(ram_addresses[i])] = data;
		end
		for (int i = 0; i < RAM_TESTS; i++) begin
			dbus_access(1'b0, ram_addresses[i], '0, rdata, latency);
			check_value("o_dbus.rdata", ram_model[ram_index(ram_addresses[i])], rdata);
		end
		// Next alias of the same word
		data = $random(seed);
		dbus_access(1'b1, 32'h1000_0010, data, rdata, latency);
		dbus_access(1'b0, 32'h1000_0010 + 32'(RAM_WORDS * 4), '0, rdata, latency);
		check_value("o_dbus.rdata", data, rdata);
		ram_model[ram_index(32'h1000_0010)] = data;

		// ====================================================================
		// Both ports at once
		// ====================================================================
		// A lone instruction fetch leaves the next tie to the data port
		ibus_read(ram_addresses[0], rdata, ibus_latency);
		check_value("o_ibus.rdata", ram_model[ram_index(ram_addresses[0])], rdata);
		check_value("ibus latency", LATENCY, ibus_latency);
		data = $random(seed);
		fork
			dbus_access(1'b1, 32'h1000_0080, data, rnd, latency);
			ibus_read(32'h1000_0080, rdata, ibus_latency);
		join
		ram_model[ram_index(32'h1000_0080)] = data;
		check_value("o_ibus.rdata", data, rdata);
		check_value("dbus latency", LATENCY, latency);
		check_value("ibus latency", 2 * LATENCY, ibus_latency);

		// ====================================================================
		// Far registers behind the bridge
		// ====================================================================
		data = $random(seed);
		dbus_access(1'b1, {REGION_BRIDGE, FAR_LED, 24'h0}, data, rdata, latency);
		led_model = data[LED_WIDTH-1:0];
		check_value("o_leds", DATA_WIDTH'(led_model), DATA_WIDTH'(leds));
		dbus_access(1'b0, {REGION_BRIDGE, FAR_LED, 24'h0}, '0, rdata, latency);
		check_value("o_dbus.rdata", DATA_WIDTH'(led_model), rdata);
		scratch_model = $random(seed);
		dbus_access(1'b1, {REGION_BRIDGE, FAR_SCRATCH, 24'h0}, scratch_model, rdata, latency);
		dbus_access(1'b0, {REGION_BRIDGE, FAR_SCRATCH, 24'h0}, '0, rdata, latency);
		check_value("o_dbus.rdata", scratch_model, rdata);
		dbus_access(1'b0, {REGION_BRIDGE, FAR_ID, 24'h0}, '0, rdata, latency);
		check_value("o_dbus.rdata", SOC_ID, rdata);
		dbus_access(1'b1, {REGION_BRIDGE, 4'h9, 24'h0}, data, rdata, latency);
		dbus_access(1'b0, {REGION_BRIDGE, 4'h9, 24'h0}, '0, rdata, latency);
		check_value("o_dbus.rdata", 0, rdata);

		// ====================================================================
		// Unmapped region and sticky fault
		// ====================================================================
		fault_flag_model    = 1'b1;
		fault_address_model = 32'h3000_0120;
		dbus_access(1'b0, fault_address_model, '0, rdata, latency);
		check_value("o_dbus.rdata", 0, rdata);
		check_value("o_bus_fault", DATA_WIDTH'(fault_flag_model), DATA_WIDTH'(bus_fault));
		check_value("o_fault_address", fault_address_model, fault_address);
		dbus_access(1'b1, 32'h3ABC_0004, data, rdata, latency);
		check_value("o_fault_address", fault_address_model, fault_address);
		apply_reset();
		fault_flag_model    = 1'b0;
		fault_address_model = '0;
		check_value("o_bus_fault", DATA_WIDTH'(fault_flag_model), DATA_WIDTH'(bus_fault));
		check_value("o_fault_address", fault_address_model, fault_address);
		check_value("o_leds", 0, DATA_WIDTH'(leds));

		repeat (4) @(posedge clock);
		check_value("o_ibus.ready count", ibus_issued, ibus_readies);
		check_value("o_dbus.ready count", dbus_issued, dbus_readies);
		$display("Errors: %0d value, %0d assertion", value_errors,
			u_soc_top.u_bus_access.u_soc_props.failures);
		if (value_errors == 0 && u_soc_top.u_bus_access.u_soc_props.failures == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
